// ==== csr_golden.txt ====
# kind name a b c d (hex); csr: op addr wdata exp_rdata, trap: flags pc - exp_redirect_pc
# aw: - addr data -, ar/arh: - addr - exp_rdata, ari/cri: - addr, irq: - pc - exp_redirect_pc
csr csrrw_mscratch 1 340 12345678 00000000
csr read_mscratch 2 340 0 12345678
csr csrrs_mscratch 2 340 000000f0 12345678
csr csrrc_mscratch 3 340 00000078 123456f8
csr check_mscratch 2 340 0 12345680
csr csrrw_mtvec 1 305 00000107 00000000
csr read_mtvec 2 305 0 00000104
csr read_misa 2 301 0 40000100
csr write_misa 1 301 ffffffff 40000100
csr reread_misa 2 301 0 40000100
csr read_mhartid 2 f14 0 00000005
csr write_mhartid 1 f14 0 00000005
csr reread_mhartid 2 f14 0 00000005
cri minstret_rises 0 b02 0 0
csr set_mie 2 300 00000008 00000000
trap ecall 1 00001000 0 00000104
csr mepc_ecall 2 341 0 00001000
csr mcause_ecall 2 342 0 0000000b
csr mstatus_ecall 2 300 0 00000080
trap mret 4 00001100 0 00001000
csr mstatus_mret 2 300 0 00000088
trap ebreak 2 00002000 0 00000104
csr mcause_ebreak 2 342 0 00000003
csr mepc_ebreak 2 341 0 00002000
aw write_cmp_lo 0 8 deadbeef 0
ar read_cmp_lo 0 8 0 deadbeef
aw write_cmp_hi 0 c 12345678 0
ar read_cmp_hi 0 c 0 12345678
arh held_read 0 c 0 12345678
ar unmapped_read 0 2 0 00000000
ari mtime_rises 0 0 0 0
aw cmp_lo_zero 0 8 00000000 0
aw cmp_hi_zero 0 c 00000000 0
csr set_mie_again 2 300 00000008 00000080
irq timer_irq 0 00003000 0 00000104
csr mcause_timer 2 342 0 80000007
trap mret_timer 4 00003100 0 00003000
csr read_mip 2 344 0 00000080

// ==== src.f ====
rv_machine_pkg.sv
trap_event_if.sv
csr_file.sv
trap_ctrl.sv
clint_timer.sv
machine_ctrl_top.sv
tb_checker.sv
tb_top.sv

// ==== Makefile ====
.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -Wno-fatal -f src.f --top-module tb_top -Mdir obj_dir

run: compile
	@out="$$(./obj_dir/Vtb_top)"; \
	echo "$$out"; \
	echo "$$out" | grep -q "^Everything OK$$"

clean:
	rm -rf obj_dir

// ==== tb_top.sv ====
`default_nettype none
`timescale 1ns/100ps

module tb_top;

    localparam int wait_limit = 50;

    logic                      clk;
    logic                      rst;
    logic                      inst_valid;
    rv_machine_pkg::xlen_t     inst_pc;
    rv_machine_pkg::csr_op_e   csr_op;
    rv_machine_pkg::csr_addr_t csr_addr;
    rv_machine_pkg::xlen_t     csr_wdata;
    logic                      inst_ecall;
    logic                      inst_ebreak;
    logic                      inst_mret;
    rv_machine_pkg::xlen_t     csr_rdata;
    logic                      redirect;
    rv_machine_pkg::xlen_t     redirect_pc;
    rv_machine_pkg::axi_addr_t awaddr;
    logic                      awvalid;
    logic                      awready;
    rv_machine_pkg::xlen_t     wdata;
    logic [3:0]                wstrb;
    logic                      wvalid;
    logic                      wready;
    logic [1:0]                bresp;
    logic                      bvalid;
    logic                      bready;
    rv_machine_pkg::axi_addr_t araddr;
    logic                      arvalid;
    logic                      arready;
    rv_machine_pkg::xlen_t     rdata;
    logic [1:0]                rresp;
    logic                      rvalid;
    logic                      rready;
    logic                      timeout_hit;

    machine_ctrl_top #(
        .hart_id (32'h5)
    ) DUT (
        .clk (clk), .rst (rst),
        .inst_valid (inst_valid), .inst_pc (inst_pc), .csr_op (csr_op),
        .csr_addr (csr_addr), .csr_wdata (csr_wdata), .inst_ecall (inst_ecall),
        .inst_ebreak (inst_ebreak), .inst_mret (inst_mret), .csr_rdata (csr_rdata),
        .redirect (redirect), .redirect_pc (redirect_pc),
        .awaddr (awaddr), .awvalid (awvalid), .awready (awready), .wdata (wdata),
        .wstrb (wstrb), .wvalid (wvalid), .wready (wready), .bresp (bresp),
        .bvalid (bvalid), .bready (bready), .araddr (araddr), .arvalid (arvalid),
        .arready (arready), .rdata (rdata), .rresp (rresp), .rvalid (rvalid),
        .rready (rready)
    );

    tb_checker u_checker (
        .clk (clk), .rst (rst), .csr_rdata (csr_rdata), .redirect (redirect),
        .redirect_pc (redirect_pc), .rdata (rdata), .rresp (rresp), .rvalid (rvalid),
        .bresp (bresp), .bvalid (bvalid)
    );

    always #50 clk = ~clk;

    task automatic report_timeout(input string name, input string what);
        $display("%s: timed out waiting for %s", name, what);
        timeout_hit = 1'b1;
    endtask

    task automatic clear_inputs();
        inst_valid  = 1'b0;
        inst_pc     = '0;
        csr_op      = rv_machine_pkg::none;
        csr_addr    = '0;
        csr_wdata   = '0;
        inst_ecall  = 1'b0;
        inst_ebreak = 1'b0;
        inst_mret   = 1'b0;
    endtask

    // flags: bit 0 ecall, bit 1 ebreak, bit 2 mret
    task automatic drive_beat(input logic [1:0] op, input logic [31:0] addr,
                              input logic [31:0] wd, input logic [2:0] flags,
                              input logic [31:0] pc);
        @(negedge clk);
        inst_valid  = 1'b1;
        inst_pc     = pc;
        csr_op      = rv_machine_pkg::csr_op_e'(op);
        csr_addr    = addr[11:0];
        csr_wdata   = wd;
        inst_ecall  = flags[0];
        inst_ebreak = flags[1];
        inst_mret   = flags[2];
    endtask

    task automatic axi_write(input string name, input logic [3:0] addr,
                             input logic [31:0] data);
        int t;
        @(negedge clk);
        awaddr  = addr;
        wdata   = data;
        wstrb   = 4'hf;
        awvalid = 1'b1;
        wvalid  = 1'b1;
        t = 0;
        #10;
        while (!(awready && wready) && t < wait_limit) begin
            t++;
            @(negedge clk);
            #10;
        end
        if (!(awready && wready)) begin
            report_timeout(name, "awready and wready");
            return;
        end
        @(negedge clk);
        awvalid = 1'b0;
        wvalid  = 1'b0;
        t = 0;
        while (!bvalid && t < wait_limit) begin
            t++;
            @(negedge clk);
        end
        if (!bvalid) begin
            report_timeout(name, "bvalid");
            return;
        end
        u_checker.arm(name, 3, 1'b0, 32'h0);
        @(negedge clk);
    endtask

    // leaves the read response pending, the caller checks and accepts it
    task automatic axi_read(input string name, input logic [3:0] addr, input logic hold,
                            output logic [31:0] data);
        int t;
        @(negedge clk);
        araddr  = addr;
        arvalid = 1'b1;
        rready  = !hold;
        t = 0;
        #10;
        while (!arready && t < wait_limit) begin
            t++;
            @(negedge clk);
            #10;
        end
        if (!arready) begin
            report_timeout(name, "arready");
            return;
        end
        @(negedge clk);
        arvalid = 1'b0;
        t = 0;
        while (!rvalid && t < wait_limit) begin
            t++;
            @(negedge clk);
        end
        if (!rvalid) begin
            report_timeout(name, "rvalid");
            return;
        end
        data = rdata;
    endtask

    initial begin
        #1_000_000;
        $display("simulation ran past its time limit");
        $display("Something failed");
        $finish;
    end

    initial begin
        int          fh;
        int          n;
        int          t;
        string       line;
        string       kind;
        string       name;
        logic [31:0] fa;
        logic [31:0] fb;
        logic [31:0] fc;
        logic [31:0] fe;
        logic [31:0] first;
        logic [31:0] second;
        void'($urandom(32'hfd44));
        clk         = 1'b0;
        rst         = 1'b1;
        timeout_hit = 1'b0;
        clear_inputs();
        awaddr  = '0;
        awvalid = 1'b0;
        wdata   = '0;
        wstrb   = '0;
        wvalid  = 1'b0;
        bready  = 1'b1;
        araddr  = '0;
        arvalid = 1'b0;
        rready  = 1'b1;
        repeat (8) @(negedge clk);
        rst = 1'b0;
        fh = $fopen("csr_golden.txt", "r");
        if (fh == 0) begin
            $display("cannot open csr_golden.txt");
            timeout_hit = 1'b1;
        end
        while (fh != 0 && !timeout_hit && !$feof(fh)) begin
            n = $fgets(line, fh);
            if (n == 0 || line.substr(0, 0) == "#") begin
                continue;
            end
            n = $sscanf(line, "%s %s %h %h %h %h", kind, name, fa, fb, fc, fe);
            if (n != 6) begin
                continue;
            end
            if (kind == "csr" || kind == "trap") begin
                if (kind == "csr") begin
                    drive_beat(fa[1:0], fb, fc, 3'b000, 32'h0);
                end else begin
                    drive_beat(2'b00, 32'h0, 32'h0, fa[2:0], fb);
                end
                u_checker.arm(name, (kind == "csr") ? 0 : 1, 1'b0, fe);
                @(negedge clk);
            end else if (kind == "cri") begin
                drive_beat(2'b10, fb, 32'h0, 3'b000, 32'h0);
                #10;
                first = csr_rdata;
                // plain beats in between, each one retires
                repeat (3) drive_beat(2'b00, 32'h0, 32'h0, 3'b000, 32'h0);
                drive_beat(2'b10, fb, 32'h0, 3'b000, 32'h0);
                u_checker.arm(name, 0, 1'b1, first);
                @(negedge clk);
            end else if (kind == "irq") begin
                t = 0;
                n = 0;
                while (n == 0 && t < wait_limit) begin
                    drive_beat(2'b00, 32'h0, 32'h0, 3'b000, fb);
                    #10;
                    if (redirect) begin
                        n = 1;
                        u_checker.arm(name, 1, 1'b0, fe);
                    end
                    t++;
                end
                @(negedge clk);
                if (n == 0) begin
                    report_timeout(name, "redirect");
                end
            end else if (kind == "aw") begin
                axi_write(name, fb[3:0], fc);
            end else if (kind == "ar" || kind == "arh") begin
                axi_read(name, fb[3:0], kind == "arh", first);
                if (!timeout_hit && kind == "arh") begin
                    // response must stay put while rready is low
                    repeat (3) begin
                        u_checker.arm(name, 2, 1'b0, fe);
                        @(negedge clk);
                    end
                    rready = 1'b1;
                end
                if (!timeout_hit) begin
                    u_checker.arm(name, 2, 1'b0, fe);
                    @(negedge clk);
                end
            end else if (kind == "ari") begin
                axi_read(name, fb[3:0], 1'b0, first);
                @(negedge clk);
                if (!timeout_hit) begin
                    axi_read(name, fb[3:0], 1'b0, second);
                end
                if (!timeout_hit) begin
                    u_checker.arm(name, 2, 1'b1, first);
                    @(negedge clk);
                end
            end else begin
                $display("unknown vector kind %s in golden file", kind);
                timeout_hit = 1'b1;
            end
            clear_inputs();
            repeat ($urandom % 3) @(negedge clk);
        end
        if (fh != 0) begin
            $fclose(fh);
        end
        repeat (2) @(negedge clk);
        u_checker.report_counts();
        if (!timeout_hit && u_checker.fail_count == 0 && u_checker.pass_count > 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== tb_checker.sv ====
`default_nettype none
`timescale 1ns/100ps

module tb_checker (
    input wire logic                  clk,
    input wire logic                  rst,
    input wire rv_machine_pkg::xlen_t csr_rdata,
    input wire logic                  redirect,
    input wire rv_machine_pkg::xlen_t redirect_pc,
    input wire rv_machine_pkg::xlen_t rdata,
    input wire logic [1:0]            rresp,
    input wire logic                  rvalid,
    input wire logic [1:0]            bresp,
    input wire logic                  bvalid
);

    int                    pass_count = 0;
    int                    fail_count = 0;
    logic                  armed = 1'b0;
    string                 test_name;
    int                    sel;
    logic                  greater;
    rv_machine_pkg::xlen_t expected;

    // sel: 0 csr_rdata, 1 redirect_pc, 2 axi rdata, 3 bresp
    task automatic arm(input string name, input int which, input logic gt,
                       input rv_machine_pkg::xlen_t exp);
        test_name = name;
        sel       = which;
        greater   = gt;
        expected  = exp;
        armed     = 1'b1;
    endtask

    task automatic report_counts();
        $display("checks done: %0d passed, %0d failed", pass_count, fail_count);
    endtask

    always @(posedge clk) begin
        rv_machine_pkg::xlen_t actual;
        logic                  present;
        logic                  match;
        if (armed && !rst) begin
            armed   = 1'b0;
            present = 1'b1;
            case (sel)
                0: actual = csr_rdata;
                1: begin
                    actual  = redirect_pc;
                    present = redirect;
                end
                2: begin
                    actual  = rdata;
                    present = rvalid;
                end
                default: begin
                    actual  = {30'd0, bresp};
                    present = bvalid;
                end
            endcase
            match = greater ? (actual > expected) : (actual == expected);
            if (!present) begin
                fail_count++;
                $display("%s: the expected response or redirect was not there", test_name);
            end else if (!match) begin
                fail_count++;
                $display("FAILED %s expected %s%h actual %h", test_name,
                         greater ? "above " : "", expected, actual);
            end else if (sel == 2 && rresp != 2'b00) begin
                fail_count++;
                $display("FAILED %s rresp expected 00 actual %b", test_name, rresp);
            end else begin
                pass_count++;
                $display("ok %s %h", test_name, actual);
            end
        end
    end

endmodule

`default_nettype wire

// ==== machine_ctrl_top.sv ====
`default_nettype none
`timescale 1ns/100ps

module machine_ctrl_top #(
    parameter rv_machine_pkg::xlen_t hart_id = '0
) (
    input  wire logic                      clk,
    input  wire logic                      rst,

    // commit beat
    input  wire logic                      inst_valid,
    input  wire rv_machine_pkg::xlen_t     inst_pc,
    input  wire rv_machine_pkg::csr_op_e   csr_op,
    input  wire rv_machine_pkg::csr_addr_t csr_addr,
    input  wire rv_machine_pkg::xlen_t     csr_wdata,
    input  wire logic                      inst_ecall,
    input  wire logic                      inst_ebreak,
    input  wire logic                      inst_mret,
    output rv_machine_pkg::xlen_t          csr_rdata,
    output logic                           redirect,
    output rv_machine_pkg::xlen_t          redirect_pc,

    // axi4-lite timer port
    input  wire rv_machine_pkg::axi_addr_t awaddr,
    input  wire logic                      awvalid,
    output logic                           awready,
    input  wire rv_machine_pkg::xlen_t     wdata,
    input  wire logic [3:0]                wstrb,
    input  wire logic                      wvalid,
    output logic                           wready,
    output logic [1:0]                     bresp,
    output logic                           bvalid,
    input  wire logic                      bready,
    input  wire rv_machine_pkg::axi_addr_t araddr,
    input  wire logic                      arvalid,
    output logic                           arready,
    output rv_machine_pkg::xlen_t          rdata,
    output logic [1:0]                     rresp,
    output logic                           rvalid,
    input  wire logic                      rready
);

    logic mtip;

    trap_event_if ev ();

    csr_file #(
        .hart_id (hart_id)
    ) u_csr_file (
        .clk        (clk),
        .rst        (rst),
        .inst_valid (inst_valid),
        .csr_op     (csr_op),
        .csr_addr   (csr_addr),
        .csr_wdata  (csr_wdata),
        .csr_rdata  (csr_rdata),
        .mtip       (mtip),
        .ev         (ev.csr)
    );

    trap_ctrl u_trap_ctrl (
        .inst_valid  (inst_valid),
        .inst_pc     (inst_pc),
        .inst_ecall  (inst_ecall),
        .inst_ebreak (inst_ebreak),
        .inst_mret   (inst_mret),
        .mtip        (mtip),
        .redirect    (redirect),
        .redirect_pc (redirect_pc),
        .ev          (ev.ctrl)
    );

    clint_timer u_clint_timer (
        .clk     (clk),
        .rst     (rst),
        .awaddr  (awaddr),
        .awvalid (awvalid),
        .awready (awready),
        .wdata   (wdata),
        .wstrb   (wstrb),
        .wvalid  (wvalid),
        .wready  (wready),
        .bresp   (bresp),
        .bvalid  (bvalid),
        .bready  (bready),
        .araddr  (araddr),
        .arvalid (arvalid),
        .arready (arready),
        .rdata   (rdata),
        .rresp   (rresp),
        .rvalid  (rvalid),
        .rready  (rready),
        .mtip    (mtip)
    );

endmodule

`default_nettype wire

// ==== clint_timer.sv ====
`default_nettype none
`timescale 1ns/100ps

module clint_timer (
    input  wire logic                      clk,
    input  wire logic                      rst,

    input  wire rv_machine_pkg::axi_addr_t awaddr,
    input  wire logic                      awvalid,
    output logic                           awready,
    input  wire rv_machine_pkg::xlen_t     wdata,
    input  wire logic [3:0]                wstrb,
    input  wire logic                      wvalid,
    output logic                           wready,
    output logic [1:0]                     bresp,
    output logic                           bvalid,
    input  wire logic                      bready,

    input  wire rv_machine_pkg::axi_addr_t araddr,
    input  wire logic                      arvalid,
    output logic                           arready,
    output rv_machine_pkg::xlen_t          rdata,
    output logic [1:0]                     rresp,
    output logic                           rvalid,
    input  wire logic                      rready,

    output logic                           mtip
);

    logic [63:0]           mtime;
    logic [63:0]           mtime_next;
    logic [63:0]           mtimecmp;
    logic                  wr_fire;
    logic                  rd_fire;
    logic                  rd_en;
    rv_machine_pkg::xlen_t rd_word;

    function automatic rv_machine_pkg::xlen_t merge_bytes(
        input rv_machine_pkg::xlen_t old_word,
        input rv_machine_pkg::xlen_t new_word,
        input logic [3:0]            strb
    );
        rv_machine_pkg::xlen_t res;
        res = old_word;
        for (int i = 0; i < 4; i++) begin
            if (strb[i]) begin
                res[8*i +: 8] = new_word[8*i +: 8];
            end
        end
        return res;
    endfunction

    // address and data must arrive together
    assign wr_fire = awvalid && wvalid && !bvalid;
    assign awready = wr_fire;
    assign wready  = wr_fire;
    assign bresp   = 2'b00;

    assign arready = rd_en && !rvalid;
    assign rd_fire = arvalid && arready;
    assign rresp   = 2'b00;

    always_comb begin
        mtime_next = mtime + 64'd1;
        if (wr_fire && awaddr == rv_machine_pkg::off_mtime_lo) begin
            mtime_next[31:0] = merge_bytes(mtime[31:0], wdata, wstrb);
        end
        if (wr_fire && awaddr == rv_machine_pkg::off_mtime_hi) begin
            mtime_next[63:32] = merge_bytes(mtime[63:32], wdata, wstrb);
        end
    end

    always_comb begin
        case (araddr)
            rv_machine_pkg::off_mtime_lo:    rd_word = mtime[31:0];
            rv_machine_pkg::off_mtime_hi:    rd_word = mtime[63:32];
            rv_machine_pkg::off_mtimecmp_lo: rd_word = mtimecmp[31:0];
            rv_machine_pkg::off_mtimecmp_hi: rd_word = mtimecmp[63:32];
            default:                         rd_word = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            mtime    <= '0;
            mtimecmp <= '1;
            mtip     <= 1'b0;
        end else begin
            mtime <= mtime_next;
            if (wr_fire && awaddr == rv_machine_pkg::off_mtimecmp_lo) begin
                mtimecmp[31:0] <= merge_bytes(mtimecmp[31:0], wdata, wstrb);
            end
            if (wr_fire && awaddr == rv_machine_pkg::off_mtimecmp_hi) begin
                mtimecmp[63:32] <= merge_bytes(mtimecmp[63:32], wdata, wstrb);
            end
            mtip <= mtime >= mtimecmp;
        end
    end

    // response channels
    always_ff @(posedge clk) begin
        if (rst) begin
            bvalid <= 1'b0;
            rvalid <= 1'b0;
            rd_en  <= 1'b0;
        end else begin
            rd_en <= 1'b1;
            if (wr_fire) begin
                bvalid <= 1'b1;
            end else if (bready) begin
                bvalid <= 1'b0;
            end
            if (rd_fire) begin
                rvalid <= 1'b1;
            end else if (rready) begin
                rvalid <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rd_fire) begin
            rdata <= rd_word;
        end
    end

    a_bvalid_held: assert property (
        @(posedge clk) disable iff (rst) bvalid && !bready |=> bvalid
    ) else $error("bvalid dropped before bready");

    a_rvalid_held: assert property (
        @(posedge clk) disable iff (rst) rvalid && !rready |=> rvalid && $stable(rdata)
    ) else $error("read response changed before rready");

endmodule

`default_nettype wire

// ==== trap_ctrl.sv ====
`default_nettype none
`timescale 1ns/100ps

module trap_ctrl (
    input  wire logic                  inst_valid,
    input  wire rv_machine_pkg::xlen_t inst_pc,
    input  wire logic                  inst_ecall,
    input  wire logic                  inst_ebreak,
    input  wire logic                  inst_mret,
    input  wire logic                  mtip,
    output logic                       redirect,
    output rv_machine_pkg::xlen_t      redirect_pc,
    trap_event_if.ctrl                 ev
);

    logic exc;
    logic irq;
    logic ret;

    // exceptions first, then the timer, mret last
    assign exc = inst_valid && (inst_ecall || inst_ebreak);
    assign irq = inst_valid && mtip && ev.irq_enabled && !exc;
    assign ret = inst_valid && inst_mret && !exc && !irq;

    always_comb begin
        if (inst_ecall) begin
            ev.trap_cause = rv_machine_pkg::cause_ecall;
        end else if (inst_ebreak) begin
            ev.trap_cause = rv_machine_pkg::cause_ebreak;
        end else begin
            ev.trap_cause = rv_machine_pkg::cause_mtimer;
        end
    end

    assign ev.take_trap = exc || irq;
    assign ev.do_mret   = ret;
    // pc of the beat that did not retire
    assign ev.trap_epc  = inst_pc;

    assign redirect    = exc || irq || ret;
    assign redirect_pc = (exc || irq) ? ev.mtvec : ev.mepc;

endmodule

`default_nettype wire

// ==== csr_file.sv ====
`default_nettype none
`timescale 1ns/100ps

module csr_file #(
    parameter rv_machine_pkg::xlen_t hart_id = '0
) (
    input  wire logic                      clk,
    input  wire logic                      rst,
    input  wire logic                      inst_valid,
    input  wire rv_machine_pkg::csr_op_e   csr_op,
    input  wire rv_machine_pkg::csr_addr_t csr_addr,
    input  wire rv_machine_pkg::xlen_t     csr_wdata,
    output rv_machine_pkg::xlen_t          csr_rdata,
    input  wire logic                      mtip,
    trap_event_if.csr                      ev
);

    // rv32i, mxl = 1
    localparam rv_machine_pkg::xlen_t misa_value = 32'h4000_0100;
    localparam rv_machine_pkg::xlen_t mstatus_mask =
        (rv_machine_pkg::xlen_t'(1) << rv_machine_pkg::mstatus_mie) |
        (rv_machine_pkg::xlen_t'(1) << rv_machine_pkg::mstatus_mpie);
    localparam rv_machine_pkg::xlen_t mie_mask =
        rv_machine_pkg::xlen_t'(1) << rv_machine_pkg::mie_mtie;

    rv_machine_pkg::xlen_t mstatus;
    rv_machine_pkg::xlen_t mie;
    rv_machine_pkg::xlen_t mtvec;
    rv_machine_pkg::xlen_t mscratch;
    rv_machine_pkg::xlen_t mepc;
    rv_machine_pkg::xlen_t mcause;
    rv_machine_pkg::xlen_t mcycle;
    rv_machine_pkg::xlen_t minstret;
    rv_machine_pkg::xlen_t mip;

    rv_machine_pkg::xlen_t old_val;
    rv_machine_pkg::xlen_t wr_val;
    logic                  wr_en;

    always_comb begin
        mip = '0;
        mip[rv_machine_pkg::mip_mtip] = mtip;
    end

    always_comb begin
        case (csr_addr)
            rv_machine_pkg::csr_mstatus:   old_val = mstatus;
            rv_machine_pkg::csr_misa:      old_val = misa_value;
            rv_machine_pkg::csr_mie:       old_val = mie;
            rv_machine_pkg::csr_mtvec:     old_val = mtvec;
            rv_machine_pkg::csr_mscratch:  old_val = mscratch;
            rv_machine_pkg::csr_mepc:      old_val = mepc;
            rv_machine_pkg::csr_mcause:    old_val = mcause;
            rv_machine_pkg::csr_mip:       old_val = mip;
            rv_machine_pkg::csr_mcycle:    old_val = mcycle;
            rv_machine_pkg::csr_minstret:  old_val = minstret;
            rv_machine_pkg::csr_mvendorid: old_val = '0;
            rv_machine_pkg::csr_marchid:   old_val = '0;
            rv_machine_pkg::csr_mimpid:    old_val = '0;
            rv_machine_pkg::csr_mhartid:   old_val = hart_id;
            default:                       old_val = '0;
        endcase
    end

    always_comb begin
        case (csr_op)
            rv_machine_pkg::rw: wr_val = csr_wdata;
            rv_machine_pkg::rs: wr_val = old_val | csr_wdata;
            rv_machine_pkg::rc: wr_val = old_val & ~csr_wdata;
            default:            wr_val = old_val;
        endcase
    end

    // an interrupted beat does not retire, so its write is dropped
    assign wr_en = inst_valid && csr_op != rv_machine_pkg::none && !ev.take_trap;

    assign csr_rdata      = old_val;
    assign ev.mtvec       = mtvec;
    assign ev.mepc        = mepc;
    assign ev.irq_enabled = mstatus[rv_machine_pkg::mstatus_mie] &&
                            mie[rv_machine_pkg::mie_mtie];

    always_ff @(posedge clk) begin
        if (rst) begin
            mstatus <= '0;
        end else if (ev.take_trap) begin
            mstatus[rv_machine_pkg::mstatus_mpie] <= mstatus[rv_machine_pkg::mstatus_mie];
            mstatus[rv_machine_pkg::mstatus_mie]  <= 1'b0;
        end else if (ev.do_mret) begin
            mstatus[rv_machine_pkg::mstatus_mie]  <= mstatus[rv_machine_pkg::mstatus_mpie];
            mstatus[rv_machine_pkg::mstatus_mpie] <= 1'b1;
        end else if (wr_en && csr_addr == rv_machine_pkg::csr_mstatus) begin
            mstatus <= wr_val & mstatus_mask;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            mepc   <= '0;
            mcause <= '0;
        end else if (ev.take_trap) begin
            mepc   <= ev.trap_epc;
            mcause <= ev.trap_cause;
        end else if (wr_en) begin
            if (csr_addr == rv_machine_pkg::csr_mepc) begin
                mepc <= wr_val;
            end
            if (csr_addr == rv_machine_pkg::csr_mcause) begin
                mcause <= wr_val;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            mie      <= mie_mask;
            mtvec    <= '0;
            mscratch <= '0;
        end else if (wr_en) begin
            case (csr_addr)
                rv_machine_pkg::csr_mie:      mie      <= wr_val & mie_mask;
                // vector base is word aligned, direct mode only
                rv_machine_pkg::csr_mtvec:    mtvec    <= wr_val & ~32'h3;
                rv_machine_pkg::csr_mscratch: mscratch <= wr_val;
                default: ;
            endcase
        end
    end

    // counters
    always_ff @(posedge clk) begin
        if (rst) begin
            mcycle   <= '0;
            minstret <= '0;
        end else begin
            if (wr_en && csr_addr == rv_machine_pkg::csr_mcycle) begin
                mcycle <= wr_val;
            end else begin
                mcycle <= mcycle + 1'b1;
            end
            if (wr_en && csr_addr == rv_machine_pkg::csr_minstret) begin
                minstret <= wr_val;
            end else if (inst_valid && !ev.take_trap) begin
                minstret <= minstret + 1'b1;
            end
        end
    end

    a_trap_mret_exclusive: assert property (
        @(posedge clk) disable iff (rst) !(ev.take_trap && ev.do_mret)
    ) else $error("trap and mret in the same beat");

endmodule

`default_nettype wire

// ==== trap_event_if.sv ====
`default_nettype none
`timescale 1ns/100ps

interface trap_event_if;

    // driven by trap control
    logic                  take_trap;
    rv_machine_pkg::xlen_t trap_cause;
    rv_machine_pkg::xlen_t trap_epc;
    logic                  do_mret;

    // driven by the csr file
    rv_machine_pkg::xlen_t mtvec;
    rv_machine_pkg::xlen_t mepc;
    logic                  irq_enabled;

    modport ctrl (
        output take_trap,
        output trap_cause,
        output trap_epc,
        output do_mret,
        input  mtvec,
        input  mepc,
        input  irq_enabled
    );

    modport csr (
        input  take_trap,
        input  trap_cause,
        input  trap_epc,
        input  do_mret,
        output mtvec,
        output mepc,
        output irq_enabled
    );

endinterface

`default_nettype wire

// ==== rv_machine_pkg.sv ====
`default_nettype none

package rv_machine_pkg;

    localparam int xlen = 32;

    typedef logic [xlen-1:0] xlen_t;
    typedef logic [11:0] csr_addr_t;
    typedef logic [3:0] axi_addr_t;

    // none means no csr access on this beat
    typedef enum logic [1:0] {
        none = 2'b00,
        rw   = 2'b01,
        rs   = 2'b10,
        rc   = 2'b11
    } csr_op_e;

    // machine csr addresses
    localparam csr_addr_t csr_mstatus   = 12'h300;
    localparam csr_addr_t csr_misa      = 12'h301;
    localparam csr_addr_t csr_mie       = 12'h304;
    localparam csr_addr_t csr_mtvec     = 12'h305;
    localparam csr_addr_t csr_mscratch  = 12'h340;
    localparam csr_addr_t csr_mepc      = 12'h341;
    localparam csr_addr_t csr_mcause    = 12'h342;
    localparam csr_addr_t csr_mip       = 12'h344;
    localparam csr_addr_t csr_mcycle    = 12'hb00;
    localparam csr_addr_t csr_minstret  = 12'hb02;
    localparam csr_addr_t csr_mvendorid = 12'hf11;
    localparam csr_addr_t csr_marchid   = 12'hf12;
    localparam csr_addr_t csr_mimpid    = 12'hf13;
    localparam csr_addr_t csr_mhartid   = 12'hf14;

    localparam xlen_t cause_ecall  = 32'd11;
    localparam xlen_t cause_ebreak = 32'd3;
    localparam xlen_t cause_mtimer = 32'h8000_0007;

    // clint register offsets
    localparam axi_addr_t off_mtime_lo    = 4'h0;
    localparam axi_addr_t off_mtime_hi    = 4'h4;
    localparam axi_addr_t off_mtimecmp_lo = 4'h8;
    localparam axi_addr_t off_mtimecmp_hi = 4'hc;

    localparam int mstatus_mie  = 3;
    localparam int mstatus_mpie = 7;
    localparam int mip_mtip     = 7;
    localparam int mie_mtie     = 7;

endpackage

`default_nettype wire
